//--- apb_arbiter.sv
`default_nettype none

module apb_arbiter import kp_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t host_req,
    output apb_rsp_t host_rsp,
    input  apb_req_t key_req,
    output apb_rsp_t key_rsp,
    output apb_req_t bus_req,
    input  apb_rsp_t bus_rsp
);

    logic locked;
    logic owner_key;
    logic last_key;
    logic gnt_key;
    logic active;
    logic done;

    // Held owner first, then round robin on a tie
    always_comb begin
        if (locked) begin
            gnt_key = owner_key;
        end else if (host_req.sel && key_req.sel) begin
            gnt_key = !last_key;
        end else begin
            gnt_key = key_req.sel;
        end
    end

    assign active = locked || host_req.sel || key_req.sel;

    always_comb begin
        bus_req = '0;
        if (active) begin
            bus_req = gnt_key ? key_req : host_req;
        end
    end

    assign done = bus_req.sel && bus_req.enable && bus_rsp.ready;

    // Waiting side sees ready low
    always_comb begin
        host_rsp = '0;
        key_rsp  = '0;
        if (active && gnt_key) begin
            key_rsp = bus_rsp;
        end else if (active) begin
            host_rsp = bus_rsp;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked    <= 1'b0;
            owner_key <= 1'b0;
            // Host goes first out of reset
            last_key  <= 1'b1;
        end else if (done) begin
            locked   <= 1'b0;
            last_key <= gnt_key;
        end else if (bus_req.sel) begin
            locked    <= 1'b1;
            owner_key <= gnt_key;
        end
    end

    // Granted request stays on the bus until it completes
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        (bus_req.sel && !done) |=> bus_req.sel && $stable(bus_req.write)
            && $stable(bus_req.addr) && $stable(bus_req.wdata));

    a_bus_enable_sel: assert property (@(posedge clk) disable iff (rst)
        bus_req.enable |-> bus_req.sel);

endmodule

`default_nettype wire

//--- keypad_scanner.sv
`default_nettype none

`include "kp_config.svh"

module keypad_scanner import kp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] row,
    output logic [3:0] column,
    output apb_req_t   req,
    input  apb_rsp_t   rsp
);

    localparam int DIV_W = $clog2(`KP_SCAN_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic             slot_end;
    logic             scan_end;
    logic [1:0]       col_idx;
    logic [1:0]       row_idx;
    logic             hit;
    logic             seen_cur;
    logic             seen_prev;
    logic             fire;
    logic             busy;
    logic             enable_q;
    key_code_t        code_q;

    assign slot_end = (div_cnt == DIV_W'(`KP_SCAN_DIV - 1));
    assign scan_end = slot_end && column[3];

    // Column slot timer and one-hot rotation
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            column  <= 4'b0001;
        end else if (slot_end) begin
            div_cnt <= '0;
            column  <= {column[2:0], column[3]};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_comb begin
        case (column)
            4'b0001: col_idx = 2'd0;
            4'b0010: col_idx = 2'd1;
            4'b0100: col_idx = 2'd2;
            default: col_idx = 2'd3;
        endcase
        // Lowest active row wins
        if (row[0]) begin
            row_idx = 2'd0;
        end else if (row[1]) begin
            row_idx = 2'd1;
        end else if (row[2]) begin
            row_idx = 2'd2;
        end else begin
            row_idx = 2'd3;
        end
    end

    assign hit  = |row;
    assign fire = hit && !seen_cur && !seen_prev;

    // Key activity in this scan and the one before
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_cur  <= 1'b0;
            seen_prev <= 1'b0;
        end else if (scan_end) begin
            seen_prev <= seen_cur || hit;
            seen_cur  <= 1'b0;
        end else if (hit) begin
            seen_cur <= 1'b1;
        end
    end

    // Posting master, presses arriving while busy are dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            enable_q <= 1'b0;
        end else if (!busy) begin
            if (fire) begin
                busy     <= 1'b1;
                enable_q <= 1'b0;
            end
        end else if (!enable_q) begin
            enable_q <= 1'b1;
        end else if (rsp.ready) begin
            busy     <= 1'b0;
            enable_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && fire) begin
            code_q <= {col_idx, row_idx};
        end
    end

    always_comb begin
        req        = '0;
        req.sel    = busy;
        req.enable = enable_q;
        req.write  = 1'b1;
        req.addr   = `KP_ADDR_KEY;
        req.wdata  = {28'b0, code_q};
    end

    // Ready reaches this master only in its own access phase
    a_ready_in_access: assert property (@(posedge clk) disable iff (rst)
        rsp.ready |-> req.sel && req.enable);

endmodule

`default_nettype wire

//--- kp_config.svh
`ifndef KP_CONFIG_SVH
`define KP_CONFIG_SVH

// Clock cycles each keypad column stays driven
`define KP_SCAN_DIV 4

// APB address width in bits
`define KP_AW 8

// Register byte addresses
`define KP_ADDR_KEY  8'h00
`define KP_ADDR_DISP 8'h04
`define KP_ADDR_STAT 8'h08

`endif

//--- kp_disp_top.sv
`default_nettype none

module kp_disp_top import kp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] row,
    output logic [3:0] column,
    input  apb_req_t   host_req,
    output apb_rsp_t   host_rsp,
    output logic       screen_csx,
    output logic       screen_dcx,
    output logic       screen_wrx,
    output logic [7:0] screen_data
);

    apb_req_t   key_req;
    apb_rsp_t   key_rsp;
    apb_req_t   bus_req;
    apb_rsp_t   bus_rsp;
    disp_word_u disp_word;
    logic       disp_start;
    logic       disp_busy;

    keypad_scanner keypad_scanner_inst (
        .clk    (clk),
        .rst    (rst),
        .row    (row),
        .column (column),
        .req    (key_req),
        .rsp    (key_rsp)
    );

    // Host and keypad share one bus
    apb_arbiter apb_arbiter_inst (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .key_req  (key_req),
        .key_rsp  (key_rsp),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

    mmio_regs mmio_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (bus_req),
        .rsp        (bus_rsp),
        .disp_word  (disp_word),
        .disp_start (disp_start),
        .disp_busy  (disp_busy)
    );

    screen_writer screen_writer_inst (
        .clk        (clk),
        .rst        (rst),
        .disp_word  (disp_word),
        .disp_start (disp_start),
        .disp_busy  (disp_busy),
        .csx        (screen_csx),
        .dcx        (screen_dcx),
        .wrx        (screen_wrx),
        .data       (screen_data)
    );

endmodule

`default_nettype wire

//--- kp_pkg.sv
`default_nettype none

`include "kp_config.svh"

package kp_pkg;

    // Requester side of the APB bus
    typedef struct packed {
        logic              sel;
        logic              enable;
        logic              write;
        logic [`KP_AW-1:0] addr;
        logic [31:0]       wdata;
    } apb_req_t;

    // Completer side of the APB bus
    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
    } apb_rsp_t;

    // Column index in the upper two bits, row index in the lower two
    typedef logic [3:0] key_code_t;

    // Display command, kind bit clear
    typedef struct packed {
        logic        kind;
        logic [22:0] unused;
        logic [7:0]  opcode;
    } disp_cmd_t;

    // Display pixel run, kind bit set
    typedef struct packed {
        logic        kind;
        logic [14:0] unused;
        logic [7:0]  rpt;
        logic [7:0]  pixel;
    } disp_pix_t;

    typedef union packed {
        disp_cmd_t cmd;
        disp_pix_t pix;
    } disp_word_u;

endpackage

`default_nettype wire

//--- mmio_regs.sv
`default_nettype none

`include "kp_config.svh"

module mmio_regs import kp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   req,
    output apb_rsp_t   rsp,
    output disp_word_u disp_word,
    output logic       disp_start,
    input  logic       disp_busy
);

    logic      access;
    logic      is_key;
    logic      is_disp;
    logic      is_stat;
    logic      key_wr;
    logic      key_rd;
    logic      disp_wr;
    logic      key_valid;
    key_code_t key_code;

    assign access  = req.sel && req.enable;
    assign is_key  = (req.addr == `KP_ADDR_KEY);
    assign is_disp = (req.addr == `KP_ADDR_DISP);
    assign is_stat = (req.addr == `KP_ADDR_STAT);

    assign key_wr  = access && req.write && is_key;
    assign key_rd  = access && !req.write && is_key;
    assign disp_wr = access && req.write && is_disp;

    // Display write goes out only once the writer is free
    assign disp_start = disp_wr && !disp_busy;
    assign disp_word  = req.wdata;

    always_comb begin
        rsp       = '0;
        rsp.ready = access && !(disp_wr && disp_busy);
        if (is_key) begin
            rsp.rdata = {23'b0, key_valid, 4'b0, key_code};
        end else if (is_stat) begin
            rsp.rdata = {31'b0, disp_busy};
        end
    end

    // Latest key, valid until read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_valid <= 1'b0;
            key_code  <= '0;
        end else if (key_wr) begin
            key_valid <= 1'b1;
            key_code  <= req.wdata[3:0];
        end else if (key_rd) begin
            key_valid <= 1'b0;
        end
    end

    // Writer goes busy the cycle after each start
    a_start_handshake: assert property (@(posedge clk) disable iff (rst)
        disp_start |=> disp_busy);

endmodule

`default_nettype wire

//--- screen_writer.sv
`default_nettype none

module screen_writer import kp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  disp_word_u disp_word,
    input  logic       disp_start,
    output logic       disp_busy,
    output logic       csx,
    output logic       dcx,
    output logic       wrx,
    output logic [7:0] data
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CS   = 2'd1;
    localparam logic [1:0] ST_WR   = 2'd2;
    localparam logic [1:0] ST_HI   = 2'd3;

    logic [1:0] state;
    logic [7:0] rpt_cnt;
    logic       dcx_q;
    logic [7:0] data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            rpt_cnt <= '0;
            dcx_q   <= 1'b0;
            data_q  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (disp_start) begin
                        state <= ST_CS;
                        dcx_q <= disp_word.cmd.kind;
                        if (disp_word.pix.kind) begin
                            rpt_cnt <= disp_word.pix.rpt;
                            data_q  <= disp_word.pix.pixel;
                        end else begin
                            rpt_cnt <= '0;
                            data_q  <= disp_word.cmd.opcode;
                        end
                    end
                end
                ST_CS: state <= ST_WR;
                ST_WR: state <= ST_HI;
                default: begin
                    // Another strobe for each remaining repeat
                    if (rpt_cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        rpt_cnt <= rpt_cnt - 1'b1;
                        state   <= ST_CS;
                    end
                end
            endcase
        end
    end

    assign disp_busy = (state != ST_IDLE);
    assign csx       = (state == ST_IDLE);
    assign wrx       = (state != ST_WR);
    assign dcx       = dcx_q;
    assign data      = data_q;

    // A start while a word is still going out would be lost
    a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
        disp_start |-> !disp_busy);

endmodule

`default_nettype wire

//--- tb_kp_disp_top.sv
`default_nettype none

`include "kp_config.svh"

module tb_kp_disp_top import kp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_ENTRIES = 20;
    localparam int MAX_RPT     = 40;
    localparam int SCAN_CYCLES = 4 * `KP_SCAN_DIV;
    // Worst entry: release and press windows plus two long pixel runs
    localparam int ENTRY_CYCLES = 8 * SCAN_CYCLES + 6 * (MAX_RPT + 2) + 64;

    localparam int OP_PRESS      = 0;
    localparam int OP_READ_KEY   = 1;
    localparam int OP_WRITE_DISP = 2;
    localparam int OP_READ_STAT  = 3;
    localparam int OP_DRAIN      = 4;
    localparam int OP_PRESS_DISP = 5;

    logic       clk;
    logic       rst;
    logic [3:0] row;
    logic [3:0] column;
    apb_req_t   host_req;
    apb_rsp_t   host_rsp;
    logic       screen_csx;
    logic       screen_dcx;
    logic       screen_wrx;
    logic [7:0] screen_data;

    // Keypad model state
    logic       key_down;
    logic [1:0] key_col;
    logic [1:0] key_row;

    integer      seed;
    integer      n_entries;
    logic [31:0] rdata;
    logic [31:0] rnd;

    string       names[NUM_ENTRIES];
    int          ops[NUM_ENTRIES];
    logic [3:0]  keys[NUM_ENTRIES];
    logic [31:0] words[NUM_ENTRIES];
    logic [31:0] expects[NUM_ENTRIES];

    // Strobes seen on the screen bus and strobes the words call for
    logic [8:0] seen_q[$];
    logic [8:0] exp_q[$];

    // Chip select frames seen and frames the words call for
    int         csx_frames;
    int         exp_frames;

    kp_disp_top kp_disp_top_inst (
        .clk         (clk),
        .rst         (rst),
        .row         (row),
        .column      (column),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .screen_csx  (screen_csx),
        .screen_dcx  (screen_dcx),
        .screen_wrx  (screen_wrx),
        .screen_data (screen_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Row lines follow the active column and the held key
    always @(negedge clk) begin
        if (key_down && column[key_col]) begin
            row <= 4'b0001 << key_row;
        end else begin
            row <= 4'b0000;
        end
    end

    always @(posedge screen_wrx) begin
        if (!rst) begin
            seen_q.push_back({screen_dcx, screen_data});
        end
    end

    always @(negedge screen_csx) begin
        if (!rst) begin
            csx_frames++;
        end
    end

    function automatic logic [31:0] cmd_word(input logic [7:0] opcode);
        return {1'b0, 23'b0, opcode};
    endfunction

    function automatic logic [31:0] pix_word(input logic [7:0] rpt, input logic [7:0] pixel);
        return {1'b1, 15'b0, rpt, pixel};
    endfunction

    task automatic add_entry(input string name, input int op, input logic [3:0] key,
                             input logic [31:0] word, input logic [31:0] expected);
        names[n_entries]   = name;
        ops[n_entries]     = op;
        keys[n_entries]    = key;
        words[n_entries]   = word;
        expects[n_entries] = expected;
        n_entries++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // One APB transfer from the host port, setup then access until ready
    task automatic host_access(input logic write, input logic [`KP_AW-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] data_out);
        logic done;
        done = 1'b0;
        @(negedge clk);
        host_req.sel    = 1'b1;
        host_req.enable = 1'b0;
        host_req.write  = write;
        host_req.addr   = addr;
        host_req.wdata  = wdata;
        @(negedge clk);
        host_req.enable = 1'b1;
        while (!done) begin
            // Sample well before the next rising edge
            #2;
            done     = host_rsp.ready;
            data_out = host_rsp.rdata;
            @(negedge clk);
        end
        host_req = '0;
    endtask

    // Release long enough to clear scan history, then hold the new key
    task automatic press_key(input logic [3:0] code);
        @(posedge clk);
        key_down = 1'b0;
        repeat (3 * SCAN_CYCLES) @(posedge clk);
        key_col  = code[3:2];
        key_row  = code[1:0];
        key_down = 1'b1;
        repeat (3 * SCAN_CYCLES) @(posedge clk);
    endtask

    // Kind 0 gives one command strobe, kind 1 gives repeat plus one pixel strobes
    task automatic queue_strobes(input logic [31:0] word);
        exp_frames++;
        if (word[31]) begin
            for (int i = 0; i <= int'(word[15:8]); i++) begin
                exp_q.push_back({1'b1, word[7:0]});
            end
        end else begin
            exp_q.push_back({1'b0, word[7:0]});
        end
    endtask

    task automatic drain_screen(input string name, input logic [31:0] count);
        logic [31:0] stat;
        stat = 32'h1;
        while (stat[0]) begin
            host_access(1'b0, `KP_ADDR_STAT, 32'h0, stat);
        end
        check_value(name, count, seen_q.size());
        // Chip select stays low across all strobes of one word
        check_value(name, exp_frames, csx_frames);
        for (int i = 0; i < seen_q.size(); i++) begin
            check_value(name, {23'b0, exp_q[i]}, {23'b0, seen_q[i]});
        end
        seen_q.delete();
        exp_q.delete();
        csx_frames = 0;
        exp_frames = 0;
    endtask

    task automatic build_table();
        add_entry("read_key_reset", OP_READ_KEY, 4'h0, 32'h0, 32'h000);
        add_entry("press_c1_r2", OP_PRESS, 4'b0110, 32'h0, 32'h0);
        add_entry("read_key_c1_r2", OP_READ_KEY, 4'h0, 32'h0, 32'h106);
        add_entry("reread_key_c1_r2", OP_READ_KEY, 4'h0, 32'h0, 32'h006);
        add_entry("press_c3_r0", OP_PRESS, 4'b1100, 32'h0, 32'h0);
        add_entry("read_key_c3_r0", OP_READ_KEY, 4'h0, 32'h0, 32'h10c);
        add_entry("reread_key_c3_r0", OP_READ_KEY, 4'h0, 32'h0, 32'h00c);
        add_entry("cmd_word", OP_WRITE_DISP, 4'h0, cmd_word(8'h2c), 32'h0);
        add_entry("cmd_strobes", OP_DRAIN, 4'h0, 32'h0, 32'd1);
        rnd = $random(seed);
        add_entry("pixel_rpt3", OP_WRITE_DISP, 4'h0, pix_word(8'd3, rnd[7:0]), 32'h0);
        add_entry("pixel_rpt3_strobes", OP_DRAIN, 4'h0, 32'h0, 32'd4);
        rnd = $random(seed);
        add_entry("pixel_long", OP_WRITE_DISP, 4'h0, pix_word(8'(MAX_RPT), rnd[7:0]), 32'h0);
        add_entry("stat_busy", OP_READ_STAT, 4'h0, 32'h0, 32'h1);
        // Second and third words stall behind the long run
        rnd = $random(seed);
        add_entry("pixel_b2b", OP_WRITE_DISP, 4'h0, pix_word(8'd2, rnd[7:0]), 32'h0);
        add_entry("cmd_b2b", OP_WRITE_DISP, 4'h0, cmd_word(8'h29), 32'h0);
        add_entry("b2b_strobes", OP_DRAIN, 4'h0, 32'h0, MAX_RPT + 1 + 3 + 1);
        add_entry("stat_idle", OP_READ_STAT, 4'h0, 32'h0, 32'h0);
        rnd = $random(seed);
        add_entry("press_during_disp", OP_PRESS_DISP, 4'b1001,
                  pix_word(8'(MAX_RPT), rnd[7:0]), 32'h0);
        add_entry("read_key_c2_r1", OP_READ_KEY, 4'h0, 32'h0, 32'h109);
        add_entry("arb_strobes", OP_DRAIN, 4'h0, 32'h0, 2 * (MAX_RPT + 1));
    endtask

    initial begin
        #(NUM_ENTRIES * ENTRY_CYCLES * CLK_PERIOD);
        $display("Timeout: the test table did not finish within its cycle budget");
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed       = 48;
        n_entries  = 0;
        csx_frames = 0;
        exp_frames = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        row        = 4'b0000;
        host_req   = '0;
        key_down   = 1'b0;
        key_col    = 2'd0;
        key_row    = 2'd0;
        build_table();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            case (ops[i])
                OP_PRESS: press_key(keys[i]);
                OP_READ_KEY: begin
                    host_access(1'b0, `KP_ADDR_KEY, 32'h0, rdata);
                    check_value(names[i], expects[i], rdata);
                end
                OP_WRITE_DISP: begin
                    queue_strobes(words[i]);
                    host_access(1'b1, `KP_ADDR_DISP, words[i], rdata);
                end
                OP_READ_STAT: begin
                    host_access(1'b0, `KP_ADDR_STAT, 32'h0, rdata);
                    check_value(names[i], expects[i], rdata);
                end
                OP_DRAIN: drain_screen(names[i], expects[i]);
                OP_PRESS_DISP: begin
                    queue_strobes(words[i]);
                    queue_strobes(words[i]);
                    // Key post lands while the host holds the bus on a stalled write
                    fork
                        press_key(keys[i]);
                        begin
                            host_access(1'b1, `KP_ADDR_DISP, words[i], rdata);
                            host_access(1'b1, `KP_ADDR_DISP, words[i], rdata);
                        end
                    join
                end
                default: check_value(names[i], 32'h0, ops[i]);
            endcase
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
kp_pkg.sv
keypad_scanner.sv
apb_arbiter.sv
mmio_regs.sv
screen_writer.sv
kp_disp_top.sv
tb_kp_disp_top.sv
